// ==== all.f ====
+incdir+hdl
hdl/periph_pkg.sv
hdl/apb_decode.sv
hdl/riscv_timer.sv
hdl/uart_tx.sv
hdl/periph_subsys.sv
verif/tb_periph.sv

// ==== Bender.yml ====
package:
  name: periph_subsys

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/periph_pkg.sv
      - hdl/apb_decode.sv
      - hdl/riscv_timer.sv
      - hdl/uart_tx.sv
      - hdl/periph_subsys.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_periph.sv

// ==== verif/tb_periph.sv ====
// Testbench for the peripheral block. Assumes an even PERIPH_BAUD_DIV and that only one APB access is in flight
`include "periph_defines.svh"

module tb_periph;
	timeunit 1ns;
	timeprecision 1ps;

	// Register addresses as seen by the APB requester
	localparam logic [15:0] ADDR_CTRL   = 16'h0000;
	localparam logic [15:0] ADDR_MTIME  = 16'h0008;
	localparam logic [15:0] ADDR_MTIMEH = 16'h000C;
	localparam logic [15:0] ADDR_CMP    = 16'h0010;
	localparam logic [15:0] ADDR_CMPH   = 16'h0014;
	localparam logic [15:0] ADDR_UDATA  = 16'h4000;
	localparam logic [15:0] ADDR_USTAT  = 16'h4004;
	localparam logic [15:0] ADDR_UCTRL  = 16'h4008;
	localparam logic [15:0] ADDR_HOLE   = 16'h8000;

	localparam int COUNT_CYCLES = 240;
	localparam int HALT_CYCLES  = 100;
	// Twice the summed test lengths plus room for the APB accesses
	localparam int TIMEOUT_CYCLES = 2 * (8 + COUNT_CYCLES + HALT_CYCLES
		+ 10 * `PERIPH_CLK_MHZ + 12 * `PERIPH_BAUD_DIV) + 1000;

	logic                      clk;
	logic                      rst_n;
	logic                      psel;
	logic                      penable;
	logic                      pwrite;
	logic [`PERIPH_ADDR_W-1:0] paddr;
	logic [`PERIPH_DATA_W-1:0] pwdata;
	logic [`PERIPH_DATA_W-1:0] prdata;
	logic                      pready;
	logic                      pslverr;
	logic                      dbg_halt;
	logic                      uart_tx;
	logic                      timer_irq;
	logic                      uart_irq;

	int seed;
	int err_count;
	int test_err_base;
	int tests_run;
	int tests_failed;
	int cycle_count;

	periph_subsys dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.dbg_halt  (dbg_halt),
		.uart_tx   (uart_tx),
		.timer_irq (timer_irq),
		.uart_irq  (uart_irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ------------------------------
	// Reporting
	// ------------------------------
	function automatic void log_mismatch(string msg);
		err_count++;
		$display("Fail at %0t ns: %s", $time, msg);
	endfunction

	function automatic void log_problem(string msg);
		err_count++;
		$display("Problem: %s", msg);
	endfunction

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp)
			else log_mismatch($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
	endtask

	task automatic check_true(input string what, input bit cond);
		assert (cond)
			else log_mismatch(what);
	endtask

	task automatic finish_test(input string name);
		int n;
		n = err_count - test_err_base;
		tests_run++;
		if (n != 0)
			tests_failed++;
		$display("Test %0d %s: %0d errors", tests_run, name, n);
		test_err_base = err_count;
	endtask

	// ------------------------------
	// APB and wait helpers
	// ------------------------------
	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		// Write lands on this edge
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk);
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_mtime(output logic [63:0] value);
		logic [31:0] lo;
		logic [31:0] hi;
		logic        err;
		apb_read(ADDR_MTIMEH, hi, err);
		apb_read(ADDR_MTIME, lo, err);
		value = {hi, lo};
	endtask

	task automatic wait_irq(input bit uart_sel, input int limit);
		int n;
		n = 0;
		while (!(uart_sel ? uart_irq : timer_irq) && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!(uart_sel ? uart_irq : timer_irq))
			log_problem($sformatf("%s did not rise within %0d cycles",
				uart_sel ? "uart_irq" : "timer_irq", limit));
	endtask

	// Irq is registered, so give it one edge after the last write
	task automatic settle();
		repeat (2) @(posedge clk);
		@(negedge clk);
	endtask

	// Call just after the start edge; samples mid-bit, start bit first
	task automatic sample_frame(output logic [9:0] bits);
		repeat (`PERIPH_BAUD_DIV / 2) @(negedge clk);
		for (int i = 0; i < 10; i++) begin
			bits[i] = uart_tx;
			if (i < 9)
				repeat (`PERIPH_BAUD_DIV) @(negedge clk);
		end
	endtask

	// ------------------------------
	// Bus assertions
	// ------------------------------
	assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable && !paddr[`PERIPH_HOLE_BIT] |-> !pslverr)
		else log_mismatch("pslverr high on a mapped access");

	assert property (@(posedge clk) disable iff (!rst_n)
		psel && penable && paddr[`PERIPH_HOLE_BIT] |-> pslverr && prdata == '0)
		else log_mismatch("unmapped access without pslverr or with nonzero prdata");

	assert property (@(posedge clk) disable iff (!rst_n) psel |-> pready)
		else log_mismatch("pready low during an access");

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles", cycle_count);
		$display("Some tests failed");
		$finish;
	end

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial begin
		logic [31:0] rdata;
		logic        rerr;
		logic [31:0] rand_lo;
		logic [31:0] rand_hi;
		logic [31:0] t0;
		logic [31:0] t1;
		logic [63:0] cmp;
		logic [63:0] now;
		logic [7:0]  tx_byte;
		logic [9:0]  bits;
		int          expect_ticks;

		seed          = 32'h7035c5d2;
		err_count     = 0;
		test_err_base = 0;
		tests_run     = 0;
		tests_failed  = 0;
		rst_n    = 1'b0;
		psel     = 1'b0;
		penable  = 1'b0;
		pwrite   = 1'b0;
		paddr    = '0;
		pwdata   = '0;
		dbg_halt = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Register readback and reset state
		@(negedge clk);
		check_value("tx after reset", uart_tx, 1);
		check_value("timer_irq after reset", timer_irq, 0);
		check_value("uart_irq after reset", uart_irq, 0);
		rand_lo = $random(seed);
		rand_hi = $random(seed);
		apb_write(ADDR_CMP, rand_lo);
		apb_write(ADDR_CMPH, rand_hi);
		apb_read(ADDR_CMP, rdata, rerr);
		check_value("mtimecmp low", rdata, rand_lo);
		apb_read(ADDR_CMPH, rdata, rerr);
		check_value("mtimecmp high", rdata, rand_hi);
		apb_write(ADDR_UCTRL, 32'h1);
		apb_read(ADDR_UCTRL, rdata, rerr);
		check_value("UART ctrl", rdata, 1);
		apb_write(ADDR_CMP, '1);
		apb_write(ADDR_CMPH, '1);
		finish_test("register readback");

		// Counting over a known window
		apb_write(ADDR_CTRL, 32'h1);
		// The read adds two cycles before prdata is sampled
		repeat (COUNT_CYCLES - 2) @(posedge clk);
		apb_read(ADDR_MTIME, rdata, rerr);
		expect_ticks = COUNT_CYCLES / `PERIPH_CLK_MHZ;
		check_true($sformatf("mtime %0d not within one of %0d", rdata, expect_ticks),
			int'(rdata) + 1 >= expect_ticks && int'(rdata) <= expect_ticks + 1);
		finish_test("timer counting");

		// Debug halt freezes mtime
		@(posedge clk);
		#1;
		dbg_halt = 1'b1;
		apb_read(ADDR_MTIME, t0, rerr);
		repeat (HALT_CYCLES) @(posedge clk);
		apb_read(ADDR_MTIME, t1, rerr);
		check_value("mtime across halt", t1, t0);
		@(posedge clk);
		#1;
		dbg_halt = 1'b0;
		repeat (5 * `PERIPH_CLK_MHZ) @(posedge clk);
		apb_read(ADDR_MTIME, rdata, rerr);
		check_true("mtime did not advance after halt release", rdata > t1);
		finish_test("debug halt");

		// Timer interrupt, checked only while stopped so mtime is steady
		apb_write(ADDR_CTRL, 32'h0);
		read_mtime(now);
		cmp = now + 64'd3;
		apb_write(ADDR_CMP, cmp[31:0]);
		apb_write(ADDR_CMPH, cmp[63:32]);
		settle();
		check_value("timer_irq below compare", timer_irq, now >= cmp);
		apb_write(ADDR_CTRL, 32'h1);
		wait_irq(1'b0, 5 * `PERIPH_CLK_MHZ + 10);
		apb_write(ADDR_CTRL, 32'h0);
		read_mtime(now);
		settle();
		check_value("timer_irq after wait", timer_irq, now >= cmp);
		check_value("timer_irq level", timer_irq, 1);
		apb_write(ADDR_CMP, '1);
		apb_write(ADDR_CMPH, '1);
		settle();
		check_value("timer_irq after compare reset", timer_irq, 0);
		finish_test("timer interrupt");

		// UART frame with a competing write while busy
		tx_byte = 8'($random(seed));
		@(negedge clk);
		check_value("uart_irq while idle", uart_irq, 1);
		apb_write(ADDR_UDATA, {24'h0, tx_byte});
		check_value("tx after data write", uart_tx, 0);
		fork
			sample_frame(bits);
			begin
				apb_read(ADDR_USTAT, rdata, rerr);
				check_value("UART busy during frame", rdata, 1);
				check_value("uart_irq during frame", uart_irq, 0);
				apb_write(ADDR_UDATA, {24'h0, ~tx_byte});
			end
		join
		check_value("frame bits", bits, {1'b1, tx_byte, 1'b0});
		wait_irq(1'b1, 2 * `PERIPH_BAUD_DIV);
		apb_read(ADDR_USTAT, rdata, rerr);
		check_value("UART busy after frame", rdata, 0);
		finish_test("UART frame");

		// Unmapped space
		apb_read(ADDR_HOLE, rdata, rerr);
		check_value("pslverr on hole read", rerr, 1);
		check_value("prdata on hole read", rdata, 0);
		apb_write(ADDR_HOLE | 16'h0004, $random(seed));
		apb_read(ADDR_USTAT, rdata, rerr);
		check_value("pslverr on mapped read", rerr, 0);
		finish_test("unmapped access");

		$display("%0d tests run, %0d with errors, %0d errors in total",
			tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== hdl/periph_subsys.sv ====
// Peripheral block top. Zero-wait-state APB with the timer at 0x0000 and the UART at 0x4000
`include "periph_defines.svh"

module periph_subsys (
	input  logic                      clk,
	input  logic                      rst_n,

	// APB requester
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] pwdata,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr,

	// Debug and IO
	input  logic                      dbg_halt,
	output logic                      uart_tx,
	output logic                      timer_irq,
	output logic                      uart_irq
);

	logic                      timer_psel;
	logic                      uart_psel;
	logic [`PERIPH_DATA_W-1:0] timer_prdata;
	logic [`PERIPH_DATA_W-1:0] uart_prdata;

	// ------------------------------
	// Address decode
	// ------------------------------
	apb_decode u_decode (
		.psel         (psel),
		.penable      (penable),
		.paddr        (paddr),
		.timer_prdata (timer_prdata),
		.uart_prdata  (uart_prdata),
		.timer_psel   (timer_psel),
		.uart_psel    (uart_psel),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr)
	);

	// ------------------------------
	// Peripherals
	// ------------------------------
	riscv_timer u_timer (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (timer_psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.dbg_halt  (dbg_halt),
		.prdata    (timer_prdata),
		.timer_irq (timer_irq)
	);

	uart_tx u_uart (
		.clk      (clk),
		.rst_n    (rst_n),
		.psel     (uart_psel),
		.penable  (penable),
		.pwrite   (pwrite),
		.paddr    (paddr),
		.pwdata   (pwdata),
		.prdata   (uart_prdata),
		.tx       (uart_tx),
		.uart_irq (uart_irq)
	);

endmodule

// ==== hdl/uart_tx.sv ====
// Transmit-only 8N1 UART with a fixed baud divisor. Data writes while busy are dropped
`include "periph_defines.svh"

module uart_tx import periph_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] pwdata,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      tx,
	output logic                      uart_irq
);

	localparam int BAUD_W = (`PERIPH_BAUD_DIV > 1) ? $clog2(`PERIPH_BAUD_DIV) : 1;
	localparam logic [BAUD_W-1:0] BAUD_LAST = BAUD_W'(`PERIPH_BAUD_DIV - 1);

	uart_reg_e         reg_off;
	uart_state_e       state;
	logic              wr_en;
	logic              start_wr;
	logic              busy;
	logic              irq_en;
	logic              bit_end;
	logic [BAUD_W-1:0] baud_ctr;
	logic [2:0]        bit_idx;
	logic [7:0]        shift;

	assign reg_off  = uart_reg_e'(paddr[7:0]);
	assign wr_en    = psel && penable && pwrite;
	assign busy     = (state != ST_IDLE);
	assign start_wr = wr_en && (reg_off == UART_DATA) && !busy;
	assign bit_end  = (baud_ctr == '0);

	// ------------------------------
	// Register interface
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_en <= 1'b0;
		end else if (wr_en && reg_off == UART_CTRL) begin
			irq_en <= pwdata[0];
		end
	end

	always_comb begin
		case (reg_off)
			UART_STAT: prdata = {31'b0, busy};
			UART_CTRL: prdata = {31'b0, irq_en};
			default:   prdata = '0;
		endcase
	end

	assign uart_irq = irq_en && !busy;

	// ------------------------------
	// Transmit FSM
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= ST_IDLE;
			tx       <= 1'b1;
			baud_ctr <= '0;
			bit_idx  <= '0;
		end else begin
			baud_ctr <= bit_end ? BAUD_LAST : baud_ctr - 1'b1;
			case (state)
				ST_IDLE: begin
					tx       <= 1'b1;
					baud_ctr <= BAUD_LAST;
					if (start_wr) begin
						state <= ST_START;
						tx    <= 1'b0;
					end
				end
				ST_START: if (bit_end) begin
					state   <= ST_DATA;
					tx      <= shift[0];
					bit_idx <= '0;
				end
				ST_DATA: if (bit_end) begin
					if (bit_idx == 3'd7) begin
						state <= ST_STOP;
						tx    <= 1'b1;
					end else begin
						tx      <= shift[0];
						bit_idx <= bit_idx + 1'b1;
					end
				end
				default: if (bit_end) begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// LSB goes out first
	always_ff @(posedge clk) begin
		if (start_wr) begin
			shift <= pwdata[7:0];
		end else if (bit_end && (state == ST_START || state == ST_DATA)) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	// Line idles at mark
	assert property (@(posedge clk) disable iff (!rst_n) state == ST_IDLE |-> tx)
		else $error("tx low while idle");

endmodule

// ==== hdl/riscv_timer.sv ====
// RISC-V machine timer. Offsets decode on paddr[7:0] only and each 64-bit register is written per half
`include "periph_defines.svh"

module riscv_timer import periph_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      psel,
	input  logic                      penable,
	input  logic                      pwrite,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] pwdata,
	input  logic                      dbg_halt,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      timer_irq
);

	localparam int PRESC_W = (`PERIPH_CLK_MHZ > 1) ? $clog2(`PERIPH_CLK_MHZ) : 1;
	localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`PERIPH_CLK_MHZ - 1);

	timer_reg_e         reg_off;
	logic               wr_en;
	logic               ctrl_en;
	logic               count_en;
	logic [PRESC_W-1:0] presc;
	logic               tick;
	logic [63:0]        mtime;
	logic [63:0]        mtimecmp;

	assign reg_off  = timer_reg_e'(paddr[7:0]);
	assign wr_en    = psel && penable && pwrite;
	assign count_en = ctrl_en && !dbg_halt;

	// ------------------------------
	// Control and microsecond timebase
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en <= 1'b0;
		end else if (wr_en && reg_off == TMR_CTRL) begin
			ctrl_en <= pwdata[0];
		end
	end

	// Prescaler holds its count while stopped
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			presc <= '0;
			tick  <= 1'b0;
		end else begin
			tick <= 1'b0;
			if (count_en) begin
				if (presc == '0) begin
					presc <= PRESC_LAST;
					tick  <= 1'b1;
				end else begin
					presc <= presc - 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// mtime and mtimecmp
	// ------------------------------

	// A bus write to either half wins over the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (wr_en && reg_off == TMR_MTIME) begin
			mtime[31:0] <= pwdata;
		end else if (wr_en && reg_off == TMR_MTIMEH) begin
			mtime[63:32] <= pwdata;
		end else if (tick && count_en) begin
			mtime <= mtime + 64'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mtimecmp <= '1;
		end else if (wr_en && reg_off == TMR_MTIMECMP) begin
			mtimecmp[31:0] <= pwdata;
		end else if (wr_en && reg_off == TMR_MTIMECMPH) begin
			mtimecmp[63:32] <= pwdata;
		end
	end

	// Compare registered so irq follows register changes by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	always_comb begin
		case (reg_off)
			TMR_CTRL:      prdata = {31'b0, ctrl_en};
			TMR_MTIME:     prdata = mtime[31:0];
			TMR_MTIMEH:    prdata = mtime[63:32];
			TMR_MTIMECMP:  prdata = mtimecmp[31:0];
			TMR_MTIMECMPH: prdata = mtimecmp[63:32];
			default:       prdata = '0;
		endcase
	end

	// Halted timer only moves under a bus write
	assert property (@(posedge clk) disable iff (!rst_n)
		dbg_halt && !wr_en |=> $stable(mtime))
		else $error("mtime changed during debug halt");

endmodule

// ==== hdl/apb_decode.sv ====
// Zero-wait-state APB splitter. Only the hole and UART address bits are decoded so peripherals alias
`include "periph_defines.svh"

module apb_decode import periph_pkg::*; (
	input  logic                      psel,
	input  logic                      penable,
	input  logic [`PERIPH_ADDR_W-1:0] paddr,
	input  logic [`PERIPH_DATA_W-1:0] timer_prdata,
	input  logic [`PERIPH_DATA_W-1:0] uart_prdata,
	output logic                      timer_psel,
	output logic                      uart_psel,
	output logic [`PERIPH_DATA_W-1:0] prdata,
	output logic                      pready,
	output logic                      pslverr
);

	periph_sel_e target;

	// Hole bit takes priority over the UART bit
	always_comb begin
		if (paddr[`PERIPH_HOLE_BIT]) begin
			target = SEL_NONE;
		end else if (paddr[`PERIPH_UART_BIT]) begin
			target = SEL_UART;
		end else begin
			target = SEL_TIMER;
		end
	end

	assign timer_psel = psel && (target == SEL_TIMER);
	assign uart_psel  = psel && (target == SEL_UART);

	// Read data return
	always_comb begin
		case (target)
			SEL_TIMER: prdata = timer_prdata;
			SEL_UART:  prdata = uart_prdata;
			default:   prdata = '0;
		endcase
	end

	// No back-pressure from any target
	assign pready  = 1'b1;
	assign pslverr = psel && penable && (target == SEL_NONE);

endmodule

// ==== hdl/periph_pkg.sv ====
// Shared types for the peripheral block. Register offsets are byte offsets within a peripheral
package periph_pkg;

	// Target of an APB access
	typedef enum logic [1:0] {
		SEL_TIMER = 2'd0,
		SEL_UART  = 2'd1,
		SEL_NONE  = 2'd2
	} periph_sel_e;

	// ------------------------------
	// Machine timer registers
	// ------------------------------
	typedef enum logic [7:0] {
		TMR_CTRL      = 8'h00,
		TMR_MTIME     = 8'h08,
		TMR_MTIMEH    = 8'h0C,
		TMR_MTIMECMP  = 8'h10,
		TMR_MTIMECMPH = 8'h14
	} timer_reg_e;

	// ------------------------------
	// UART registers
	// ------------------------------
	typedef enum logic [7:0] {
		UART_DATA = 8'h00,
		UART_STAT = 8'h04,
		UART_CTRL = 8'h08
	} uart_reg_e;

	// Transmit FSM
	typedef enum logic [1:0] {
		ST_IDLE  = 2'd0,
		ST_START = 2'd1,
		ST_DATA  = 2'd2,
		ST_STOP  = 2'd3
	} uart_state_e;

endpackage

// ==== hdl/periph_defines.svh ====
// Constants for the peripheral block. The clock must be a whole number of MHz and the bus is 32-bit only
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// ------------------------------
// Clocking
// ------------------------------

// Clock cycles per microsecond tick of the machine timer
`define PERIPH_CLK_MHZ 12

// Clock cycles per UART bit, kept small for quick simulation
`define PERIPH_BAUD_DIV 16

// ------------------------------
// APB bus
// ------------------------------

`define PERIPH_ADDR_W 16
`define PERIPH_DATA_W 32

// ------------------------------
// Address map
// ------------------------------

// Timer at 0x0000 and UART at 0x4000
`define PERIPH_UART_BIT 14

// Any access with this bit set falls in the hole
`define PERIPH_HOLE_BIT 15

`endif
